//--- logic/be_pkg.sv
// Back-end shared definitions

package be_pkg;

   // Instruction word layout from the top: op, rd, rs1, rs2, imm
   localparam int INSTR_W   = 20;
   localparam int OP_W      = 4;
   localparam int REG_IDX_W = 3;
   localparam int IMM_W     = 7;
   localparam int NUM_REGS  = 8;

   localparam int OP_LSB  = INSTR_W - OP_W;
   localparam int RD_LSB  = OP_LSB - REG_IDX_W;
   localparam int RS1_LSB = RD_LSB - REG_IDX_W;
   localparam int RS2_LSB = RS1_LSB - REG_IDX_W;
   localparam int IMM_LSB = 0;

   typedef enum logic [OP_W-1:0] {
      OP_ADD  = 4'd0,
      OP_SUB  = 4'd1,
      OP_AND  = 4'd2,
      OP_OR   = 4'd3,
      OP_XOR  = 4'd4,
      OP_ADDI = 4'd5,
      OP_LD   = 4'd6,
      OP_ST   = 4'd7
   } be_op_e;

   // Config space
   typedef enum logic [1:0] {
      CFG_FREEZE  = 2'd0,
      CFG_INSTRET = 2'd1,
      CFG_IRF     = 2'd2
   } be_cfg_addr_e;

endpackage : be_pkg

//--- logic/be_cfg_regs.sv
// Back-end configuration registers
`timescale 1ns/10ps

module be_cfg_regs
 import be_pkg::*;
 #(parameter int DATA_W_P = 32)
  (input                          clk_i
   , input                        rst_n_i

   , input                        cfg_we_i
   , input  be_cfg_addr_e         cfg_addr_i
   , input        [REG_IDX_W-1:0] cfg_idx_i
   , input        [DATA_W_P-1:0]  cfg_wdata_i
   , output logic [DATA_W_P-1:0]  cfg_rdata_o

   , input                        commit_v_i
   , output logic                 freeze_o

   , output logic [REG_IDX_W-1:0] irf_raddr_o
   , input        [DATA_W_P-1:0]  irf_rdata_i
   );

   logic                freeze_q;
   logic [DATA_W_P-1:0] instret_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         freeze_q  <= 1'b0;
         instret_q <= '0;
      end else begin
         if (cfg_we_i && cfg_addr_i == CFG_FREEZE) begin
            freeze_q <= cfg_wdata_i[0];
         end
         if (commit_v_i) begin
            instret_q <= instret_q + 1'b1;
         end
      end
   end

   assign freeze_o    = freeze_q;
   assign irf_raddr_o = cfg_idx_i;

   // Read mux
   always_comb begin
      case (cfg_addr_i)
         CFG_FREEZE:  cfg_rdata_o = {{(DATA_W_P-1){1'b0}}, freeze_q};
         CFG_INSTRET: cfg_rdata_o = instret_q;
         CFG_IRF:     cfg_rdata_o = irf_rdata_i;
         default:     cfg_rdata_o = '0;
      endcase
   end

endmodule : be_cfg_regs

//--- logic/be_checker.sv
// Back-end dispatch checker
`timescale 1ns/10ps

module be_checker
 import be_pkg::*;
 #(parameter int CREDITS_P = 4)
  (input                        clk_i
   , input                      rst_n_i

   , input        [INSTR_W-1:0] fe_queue_i
   , input                      fe_queue_v_i
   , output logic               fe_queue_yumi_o

   , input                      freeze_i
   , input                      credit_avail_i
   , input                      load_done_i

   , output logic               disp_v_o
   , output logic [INSTR_W-1:0] disp_instr_o
   , output logic               mem_issue_o
   );

   typedef enum logic {
      CHK_RUN,
      CHK_LOAD_WAIT
   } chk_state_e;

   chk_state_e   state_q, state_d;
   be_op_e       head_op;
   logic         head_is_mem;
   logic         head_is_ld;
   logic         no_load_block;
   logic         mem_ok;
   logic         disp_v_q;
   logic [INSTR_W-1:0] disp_instr_q;

   assign head_op     = be_op_e'(fe_queue_i[OP_LSB +: OP_W]);
   assign head_is_ld  = (head_op == OP_LD);
   assign head_is_mem = head_is_ld || (head_op == OP_ST);

   // Load writeback frees the pipe in the same cycle
   assign no_load_block = (state_q == CHK_RUN) || load_done_i;
   assign mem_ok        = !head_is_mem || credit_avail_i;

   assign fe_queue_yumi_o = fe_queue_v_i && !freeze_i && no_load_block && mem_ok;
   assign mem_issue_o     = fe_queue_yumi_o && head_is_mem;

   always_comb begin
      state_d = state_q;
      case (state_q)
         CHK_RUN: begin
            if (fe_queue_yumi_o && head_is_ld) begin
               state_d = CHK_LOAD_WAIT;
            end
         end
         CHK_LOAD_WAIT: begin
            if (load_done_i) begin
               state_d = (fe_queue_yumi_o && head_is_ld) ? CHK_LOAD_WAIT : CHK_RUN;
            end
         end
         default: state_d = CHK_RUN;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_q  <= CHK_RUN;
         disp_v_q <= 1'b0;
      end else begin
         state_q  <= state_d;
         disp_v_q <= fe_queue_yumi_o;
      end
   end

   // Dispatch register
   always_ff @(posedge clk_i) begin
      if (fe_queue_yumi_o) begin
         disp_instr_q <= fe_queue_i;
      end
   end

   assign disp_v_o     = disp_v_q;
   assign disp_instr_o = disp_instr_q;

endmodule : be_checker

//--- logic/be_calculator.sv
// Back-end register file, ALU and commit stage
`timescale 1ns/10ps

module be_calculator
 import be_pkg::*;
 #(parameter int DATA_W_P = 32)
  (input                          clk_i
   , input                        rst_n_i

   , input                        disp_v_i
   , input        [INSTR_W-1:0]   disp_instr_i

   , output logic                 mem_cmd_v_o
   , output logic                 mem_cmd_we_o
   , output logic [DATA_W_P-1:0]  mem_cmd_addr_o
   , output logic [DATA_W_P-1:0]  mem_cmd_data_o

   , input                        load_resp_v_i
   , input        [DATA_W_P-1:0]  load_resp_data_i
   , output logic                 load_done_o

   , output logic                 commit_v_o
   , output logic [REG_IDX_W-1:0] commit_rd_o
   , output logic [DATA_W_P-1:0]  commit_data_o

   , input        [REG_IDX_W-1:0] irf_raddr_i
   , output logic [DATA_W_P-1:0]  irf_rdata_o
   );

   logic [DATA_W_P-1:0]  rf_q [NUM_REGS];
   be_op_e               op;
   logic [REG_IDX_W-1:0] rd, rs1, rs2;
   logic [IMM_W-1:0]     imm;
   logic [DATA_W_P-1:0]  imm_ext;
   logic [DATA_W_P-1:0]  rs1_val, rs2_val;
   logic [DATA_W_P-1:0]  eff_addr, alu_res;
   logic                 commit_v_q;
   logic [REG_IDX_W-1:0] commit_rd_q;
   logic [DATA_W_P-1:0]  commit_data_q;
   logic [REG_IDX_W-1:0] pend_rd_q;

   // Decode
   assign op      = be_op_e'(disp_instr_i[OP_LSB +: OP_W]);
   assign rd      = disp_instr_i[RD_LSB +: REG_IDX_W];
   assign rs1     = disp_instr_i[RS1_LSB +: REG_IDX_W];
   assign rs2     = disp_instr_i[RS2_LSB +: REG_IDX_W];
   assign imm     = disp_instr_i[IMM_LSB +: IMM_W];
   assign imm_ext = {{(DATA_W_P-IMM_W){imm[IMM_W-1]}}, imm};

   // Operand read, bypassing the value retiring this cycle
   always_comb begin
      rs1_val = rf_q[rs1];
      rs2_val = rf_q[rs2];
      if (commit_v_o && commit_rd_o != '0 && commit_rd_o == rs1) begin
         rs1_val = commit_data_o;
      end
      if (commit_v_o && commit_rd_o != '0 && commit_rd_o == rs2) begin
         rs2_val = commit_data_o;
      end
   end

   assign eff_addr = rs1_val + imm_ext;

   always_comb begin
      case (op)
         OP_ADD:  alu_res = rs1_val + rs2_val;
         OP_SUB:  alu_res = rs1_val - rs2_val;
         OP_AND:  alu_res = rs1_val & rs2_val;
         OP_OR:   alu_res = rs1_val | rs2_val;
         OP_XOR:  alu_res = rs1_val ^ rs2_val;
         OP_ADDI: alu_res = eff_addr;
         default: alu_res = eff_addr;
      endcase
   end

   assign mem_cmd_v_o    = disp_v_i && (op == OP_LD || op == OP_ST);
   assign mem_cmd_we_o   = (op == OP_ST);
   assign mem_cmd_addr_o = eff_addr;
   assign mem_cmd_data_o = rs2_val;

   // Commit stage for ALU ops and stores
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         commit_v_q <= 1'b0;
      end else begin
         commit_v_q <= disp_v_i && (op != OP_LD);
      end
   end

   always_ff @(posedge clk_i) begin
      if (disp_v_i) begin
         commit_rd_q   <= (op == OP_ST) ? '0 : rd;
         commit_data_q <= (op == OP_ST) ? rs2_val : alu_res;
      end
      if (disp_v_i && op == OP_LD) begin
         pend_rd_q <= rd;
      end
   end

   // Loads retire on the response, nothing else can be in flight then
   assign load_done_o   = load_resp_v_i;
   assign commit_v_o    = commit_v_q || load_resp_v_i;
   assign commit_rd_o   = load_resp_v_i ? pend_rd_q : commit_rd_q;
   assign commit_data_o = load_resp_v_i ? load_resp_data_i : commit_data_q;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rf_q <= '{default: '0};
      end else if (commit_v_o && commit_rd_o != '0) begin
         rf_q[commit_rd_o] <= commit_data_o;
      end
   end

   assign irf_rdata_o = rf_q[irf_raddr_i];

endmodule : be_calculator

//--- logic/be_mem.sv
// Back-end memory request and response stage
`timescale 1ns/10ps

module be_mem
 #(parameter int DATA_W_P  = 32
   , parameter int CREDITS_P = 4
   )
  (input                         clk_i
   , input                       rst_n_i

   , input                       mem_issue_i
   , output logic                credit_avail_o

   , input                       mem_cmd_v_i
   , input                       mem_cmd_we_i
   , input        [DATA_W_P-1:0] mem_cmd_addr_i
   , input        [DATA_W_P-1:0] mem_cmd_data_i

   , output logic                mem_req_v_o
   , output logic                mem_req_we_o
   , output logic [DATA_W_P-1:0] mem_req_addr_o
   , output logic [DATA_W_P-1:0] mem_req_data_o
   , input                       mem_credit_i

   , input                       mem_resp_v_i
   , input        [DATA_W_P-1:0] mem_resp_data_i
   , output logic                load_resp_v_o
   , output logic [DATA_W_P-1:0] load_resp_data_o
   );

   localparam int CNT_W_LP = $clog2(CREDITS_P + 1);
   localparam logic [CNT_W_LP-1:0] CREDITS_LP = CNT_W_LP'(CREDITS_P);

   logic [CNT_W_LP-1:0] credit_cnt_q;
   logic                req_v_q;
   logic                resp_v_q;

   // Credits are spent at accept so the checker sees them gone next cycle
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         credit_cnt_q <= CREDITS_LP;
      end else begin
         case ({mem_issue_i, mem_credit_i})
            2'b10: credit_cnt_q <= credit_cnt_q - 1'b1;
            2'b01: begin
               if (credit_cnt_q != CREDITS_LP) begin
                  credit_cnt_q <= credit_cnt_q + 1'b1;
               end
            end
            default: credit_cnt_q <= credit_cnt_q;
         endcase
      end
   end

   assign credit_avail_o = (credit_cnt_q != '0);

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         req_v_q  <= 1'b0;
         resp_v_q <= 1'b0;
      end else begin
         req_v_q  <= mem_cmd_v_i;
         resp_v_q <= mem_resp_v_i;
      end
   end

   // Request and response payloads
   always_ff @(posedge clk_i) begin
      if (mem_cmd_v_i) begin
         mem_req_we_o   <= mem_cmd_we_i;
         mem_req_addr_o <= mem_cmd_addr_i;
         mem_req_data_o <= mem_cmd_data_i;
      end
      if (mem_resp_v_i) begin
         load_resp_data_o <= mem_resp_data_i;
      end
   end

   assign mem_req_v_o   = req_v_q;
   assign load_resp_v_o = resp_v_q;

endmodule : be_mem

//--- logic/be_top.sv
// Toy core execution back end
`timescale 1ns/10ps

module be_top
 import be_pkg::*;
 #(parameter int DATA_W_P  = 32
   , parameter int CREDITS_P = 4
   )
  (input                          clk_i
   , input                        rst_n_i

   // Front-end queue
   , input        [INSTR_W-1:0]   fe_queue_i
   , input                        fe_queue_v_i
   , output logic                 fe_queue_yumi_o

   // External memory
   , output logic                 mem_req_v_o
   , output logic                 mem_req_we_o
   , output logic [DATA_W_P-1:0]  mem_req_addr_o
   , output logic [DATA_W_P-1:0]  mem_req_data_o
   , input                        mem_credit_i
   , input                        mem_resp_v_i
   , input        [DATA_W_P-1:0]  mem_resp_data_i

   , output logic                 commit_v_o
   , output logic [REG_IDX_W-1:0] commit_rd_o
   , output logic [DATA_W_P-1:0]  commit_data_o

   // Configuration
   , input                        cfg_we_i
   , input  be_cfg_addr_e         cfg_addr_i
   , input        [REG_IDX_W-1:0] cfg_idx_i
   , input        [DATA_W_P-1:0]  cfg_wdata_i
   , output logic [DATA_W_P-1:0]  cfg_rdata_o
   );

   logic                 disp_v;
   logic [INSTR_W-1:0]   disp_instr;
   logic                 mem_issue, credit_avail, load_done, freeze;
   logic                 mem_cmd_v, mem_cmd_we;
   logic [DATA_W_P-1:0]  mem_cmd_addr, mem_cmd_data;
   logic                 load_resp_v;
   logic [DATA_W_P-1:0]  load_resp_data;
   logic [REG_IDX_W-1:0] irf_raddr;
   logic [DATA_W_P-1:0]  irf_rdata;

   be_cfg_regs
    #(.DATA_W_P(DATA_W_P))
    i_be_cfg_regs
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.cfg_we_i(cfg_we_i)
      ,.cfg_addr_i(cfg_addr_i)
      ,.cfg_idx_i(cfg_idx_i)
      ,.cfg_wdata_i(cfg_wdata_i)
      ,.cfg_rdata_o(cfg_rdata_o)
      ,.commit_v_i(commit_v_o)
      ,.freeze_o(freeze)
      ,.irf_raddr_o(irf_raddr)
      ,.irf_rdata_i(irf_rdata)
      );

   be_checker
    #(.CREDITS_P(CREDITS_P))
    i_be_checker
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.fe_queue_i(fe_queue_i)
      ,.fe_queue_v_i(fe_queue_v_i)
      ,.fe_queue_yumi_o(fe_queue_yumi_o)
      ,.freeze_i(freeze)
      ,.credit_avail_i(credit_avail)
      ,.load_done_i(load_done)
      ,.disp_v_o(disp_v)
      ,.disp_instr_o(disp_instr)
      ,.mem_issue_o(mem_issue)
      );

   be_calculator
    #(.DATA_W_P(DATA_W_P))
    i_be_calculator
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.disp_v_i(disp_v)
      ,.disp_instr_i(disp_instr)
      ,.mem_cmd_v_o(mem_cmd_v)
      ,.mem_cmd_we_o(mem_cmd_we)
      ,.mem_cmd_addr_o(mem_cmd_addr)
      ,.mem_cmd_data_o(mem_cmd_data)
      ,.load_resp_v_i(load_resp_v)
      ,.load_resp_data_i(load_resp_data)
      ,.load_done_o(load_done)
      ,.commit_v_o(commit_v_o)
      ,.commit_rd_o(commit_rd_o)
      ,.commit_data_o(commit_data_o)
      ,.irf_raddr_i(irf_raddr)
      ,.irf_rdata_o(irf_rdata)
      );

   be_mem
    #(.DATA_W_P(DATA_W_P)
      ,.CREDITS_P(CREDITS_P)
      )
    i_be_mem
     (.clk_i(clk_i)
      ,.rst_n_i(rst_n_i)
      ,.mem_issue_i(mem_issue)
      ,.credit_avail_o(credit_avail)
      ,.mem_cmd_v_i(mem_cmd_v)
      ,.mem_cmd_we_i(mem_cmd_we)
      ,.mem_cmd_addr_i(mem_cmd_addr)
      ,.mem_cmd_data_i(mem_cmd_data)
      ,.mem_req_v_o(mem_req_v_o)
      ,.mem_req_we_o(mem_req_we_o)
      ,.mem_req_addr_o(mem_req_addr_o)
      ,.mem_req_data_o(mem_req_data_o)
      ,.mem_credit_i(mem_credit_i)
      ,.mem_resp_v_i(mem_resp_v_i)
      ,.mem_resp_data_i(mem_resp_data_i)
      ,.load_resp_v_o(load_resp_v)
      ,.load_resp_data_o(load_resp_data)
      );

endmodule : be_top

//--- test/be_props.sv
// Credit and handshake assertions
`timescale 1ns/10ps

module be_props
 import be_pkg::*;
 #(parameter int CREDITS_P = 4)
  (input                              clk_i
   , input                            rst_n_i
   , input [$clog2(CREDITS_P+1)-1:0]  credit_cnt_i
   , input [INSTR_W-1:0]              fe_queue_i
   , input                            fe_queue_yumi_i
   , input                            load_done_i
   , input                            mem_req_v_i
   , input                            mem_credit_i
   , input                            commit_v_i
   );

   logic [$clog2(CREDITS_P+1):0] req_out_q;
   logic                         ld_pend_q;

   // Requests on the port not yet matched by a credit return
   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         req_out_q <= '0;
         ld_pend_q <= 1'b0;
      end else begin
         req_out_q <= req_out_q + mem_req_v_i - mem_credit_i;
         if (fe_queue_yumi_i && fe_queue_i[OP_LSB +: OP_W] == OP_LD) begin
            ld_pend_q <= 1'b1;
         end else if (load_done_i) begin
            ld_pend_q <= 1'b0;
         end
      end
   end

   credit_max: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      credit_cnt_i <= CREDITS_P)
      else $error("credit count above pool size");

   // Requests only go out against a held credit
   req_has_credit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      mem_req_v_i |-> req_out_q < CREDITS_P)
      else $error("memory request sent with no credit left");

   // Nothing leaves the queue while a load waits for its data
   load_blocks_queue: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ld_pend_q && !load_done_i |-> !fe_queue_yumi_i)
      else $error("queue entry accepted behind a pending load");

   reset_quiet: assert property (@(posedge clk_i)
      $rose(rst_n_i) |-> !commit_v_i && !mem_req_v_i)
      else $error("outputs active right after reset");

endmodule : be_props

bind be_top be_props #(.CREDITS_P(CREDITS_P)) i_be_props
  (.clk_i(clk_i)
   , .rst_n_i(rst_n_i)
   , .credit_cnt_i(i_be_mem.credit_cnt_q)
   , .fe_queue_i(fe_queue_i)
   , .fe_queue_yumi_i(fe_queue_yumi_o)
   , .load_done_i(i_be_calculator.load_done_o)
   , .mem_req_v_i(mem_req_v_o)
   , .mem_credit_i(mem_credit_i)
   , .commit_v_i(commit_v_o)
   );

//--- test/be_tb.sv
// Back-end testbench
`timescale 1ns/10ps

module be_tb
 import be_pkg::*;
 ();

   localparam int DATA_W    = 32;
   localparam int CREDITS   = 4;
   localparam int N_RAND    = 60;
   localparam int N_CHAIN   = 40;
   localparam int N_MEM     = 60;
   localparam int N_BURST   = 24;
   localparam int N_FREEZE  = 6;
   localparam int NUM_INSTR = N_RAND + N_CHAIN + N_MEM + N_BURST + N_FREEZE;

   logic                 clk_i = 1'b0;
   logic                 rst_n_i;
   logic [INSTR_W-1:0]   fe_queue_i;
   logic                 fe_queue_v_i, fe_queue_yumi_o;
   logic                 mem_req_v_o, mem_req_we_o, mem_credit_i, mem_resp_v_i;
   logic [DATA_W-1:0]    mem_req_addr_o, mem_req_data_o, mem_resp_data_i;
   logic                 commit_v_o;
   logic [REG_IDX_W-1:0] commit_rd_o, cfg_idx_i;
   logic [DATA_W-1:0]    commit_data_o, cfg_wdata_i, cfg_rdata_o;
   logic                 cfg_we_i;
   be_cfg_addr_e         cfg_addr_i;

   // Reference state and expected streams in program order
   logic [DATA_W-1:0]    ref_rf [NUM_REGS];
   logic [DATA_W-1:0]    ref_mem [64];
   logic [DATA_W-1:0]    model_mem [64];
   be_op_e               exp_op [$];
   logic [REG_IDX_W-1:0] exp_rd [$];
   logic [DATA_W-1:0]    exp_data [$];
   logic                 exp_we [$];
   logic [DATA_W-1:0]    exp_addr [$];
   logic [DATA_W-1:0]    exp_wdata [$];

   // Memory model schedule, in cycle numbers
   int                   credit_due [$];
   int                   resp_due [$];
   logic [DATA_W-1:0]    resp_data [$];
   int                   last_credit = 0;
   int                   last_resp = 0;
   logic [31:0]          lcg_state = 32'd67277;
   int                   cyc = 0;
   int                   credit_lag = 0;
   int                   outstanding = 0;
   int                   commit_cnt = 0;
   int                   sent_cnt = 0;

   always #20 clk_i = ~clk_i;

   be_top #(.DATA_W_P(DATA_W), .CREDITS_P(CREDITS)) i_be_top (.*);

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("test failed");
      $fatal(1, "simulation stopped on error");
   endtask

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return {17'd0, lcg_state[30:16]};
   endfunction

   function automatic int later_of(input int a, input int b);
      return (a > b) ? a : b;
   endfunction

   function automatic logic [DATA_W-1:0] fill_word(input int idx);
      return 32'hc0de_0000 + idx * 32'h0101_0013;
   endfunction

   // One instruction on the model state, memory requests queued as a side effect
   function automatic void be_ref_step(input logic [INSTR_W-1:0] instr,
                                       output logic [REG_IDX_W-1:0] rd,
                                       output logic [DATA_W-1:0] data);
      be_op_e            op;
      logic [DATA_W-1:0] a, b, imm, addr;
      op   = be_op_e'(instr[19:16]);
      a    = ref_rf[instr[12:10]];
      b    = ref_rf[instr[9:7]];
      imm  = {{(DATA_W-7){instr[6]}}, instr[6:0]};
      addr = a + imm;
      rd   = (op == OP_ST) ? '0 : instr[15:13];
      case (op)
         OP_ADD:  data = a + b;
         OP_SUB:  data = a - b;
         OP_AND:  data = a & b;
         OP_OR:   data = a | b;
         OP_XOR:  data = a ^ b;
         OP_LD:   data = ref_mem[addr[5:0]];
         OP_ST:   data = b;
         default: data = addr;
      endcase
      if (op == OP_ST)
         ref_mem[addr[5:0]] = b;
      if (op == OP_LD || op == OP_ST) begin
         exp_we.push_back(op == OP_ST);
         exp_addr.push_back(addr);
         exp_wdata.push_back(b);
      end
      if (rd != '0)
         ref_rf[rd] = data;
   endfunction

   // Mode 0 random ALU, 1 dependent chain, 2 memory mix, 3 store burst
   function automatic logic [INSTR_W-1:0] gen_instr(input int mode, input logic [2:0] prev);
      logic [3:0] op;
      logic [2:0] rd, rs1, rs2;
      logic [6:0] imm;
      op  = 4'(lcg_next() % 6);
      rd  = 3'(lcg_next());
      rs1 = 3'(lcg_next());
      rs2 = 3'(lcg_next());
      imm = 7'(lcg_next());
      if (mode == 1) begin
         rd  = 3'(1 + lcg_next() % 7);
         rs1 = prev;
         if (lcg_next() % 2 == 0)
            rs2 = prev;
      end else if (mode >= 2 && (mode == 3 || lcg_next() % 3 != 0)) begin
         // Small address window so loads hit earlier stores
         op  = (mode == 3 || lcg_next() % 2 == 0) ? 4'(OP_ST) : 4'(OP_LD);
         rs1 = '0;
         imm = 7'(lcg_next() % 8) - 7'd4;
      end
      return {op, rd, rs1, rs2, imm};
   endfunction

   task automatic check_commit(input be_op_e op, input logic [REG_IDX_W-1:0] rd,
                               input logic [DATA_W-1:0] data);
      if (commit_rd_o !== rd)
         abort_run($sformatf("[FAIL] commit_rd_o (%s) expected %h got %h",
                             op.name(), rd, commit_rd_o));
      if (commit_data_o !== data)
         abort_run($sformatf("[FAIL] commit_data_o (%s) expected %h got %h",
                             op.name(), data, commit_data_o));
   endtask

   task automatic check_mem_req(input logic we, input logic [DATA_W-1:0] addr,
                                input logic [DATA_W-1:0] data);
      if (mem_req_we_o !== we)
         abort_run($sformatf("[FAIL] mem_req_we_o expected %h got %h", we, mem_req_we_o));
      if (mem_req_addr_o !== addr)
         abort_run($sformatf("[FAIL] mem_req_addr_o expected %h got %h",
                             addr, mem_req_addr_o));
      if (we && mem_req_data_o !== data)
         abort_run($sformatf("[FAIL] mem_req_data_o expected %h got %h",
                             data, mem_req_data_o));
   endtask

   task automatic check_cfg(input be_cfg_addr_e addr, input logic [REG_IDX_W-1:0] idx,
                            input logic [DATA_W-1:0] exp);
      if (cfg_rdata_o !== exp)
         abort_run($sformatf("[FAIL] cfg_rdata_o (%s idx %0d) expected %h got %h",
                             addr.name(), idx, exp, cfg_rdata_o));
   endtask

   // Commit compare, memory model and credit accounting
   always @(negedge clk_i) begin
      if (rst_n_i && commit_v_o) begin
         if (exp_op.size() == 0)
            abort_run("a commit appeared with no instruction outstanding");
         else
            check_commit(exp_op.pop_front(), exp_rd.pop_front(), exp_data.pop_front());
         commit_cnt++;
      end
      if (rst_n_i && mem_req_v_o) begin
         if (exp_we.size() == 0)
            abort_run("a memory request appeared with none expected");
         else
            check_mem_req(exp_we.pop_front(), exp_addr.pop_front(), exp_wdata.pop_front());
         if (mem_req_we_o) begin
            model_mem[mem_req_addr_o[5:0]] = mem_req_data_o;
         end else begin
            last_resp = later_of(cyc + 1 + int'(lcg_next() % 6), last_resp + 1);
            resp_due.push_back(last_resp);
            resp_data.push_back(model_mem[mem_req_addr_o[5:0]]);
         end
         last_credit = later_of(cyc + 1 + credit_lag + int'(lcg_next() % 6), last_credit + 1);
         credit_due.push_back(last_credit);
      end
      if (rst_n_i) begin
         outstanding = outstanding + (mem_req_v_o ? 1 : 0) - (mem_credit_i ? 1 : 0);
         if (outstanding > CREDITS)
            abort_run($sformatf("[FAIL] outstanding requests expected <= %h got %h",
                                CREDITS, outstanding));
      end
   end

   // Credit returns and load responses
   always @(posedge clk_i) begin
      #2;
      cyc++;
      mem_credit_i = (credit_due.size() != 0 && credit_due[0] == cyc);
      if (mem_credit_i)
         void'(credit_due.pop_front());
      mem_resp_v_i = (resp_due.size() != 0 && resp_due[0] == cyc);
      if (mem_resp_v_i) begin
         void'(resp_due.pop_front());
         mem_resp_data_i = resp_data.pop_front();
      end
   end

   task automatic expect_instr(input logic [INSTR_W-1:0] instr);
      logic [REG_IDX_W-1:0] rd;
      logic [DATA_W-1:0]    data;
      be_ref_step(instr, rd, data);
      exp_op.push_back(be_op_e'(instr[19:16]));
      exp_rd.push_back(rd);
      exp_data.push_back(data);
   endtask

   task automatic send_instr(input logic [INSTR_W-1:0] instr, input int gap);
      logic took;
      fe_queue_v_i = 1'b0;
      repeat (gap) begin
         @(posedge clk_i);
         #2;
      end
      fe_queue_i   = instr;
      fe_queue_v_i = 1'b1;
      took         = 1'b0;
      while (!took) begin
         @(negedge clk_i);
         took = fe_queue_yumi_o;
         @(posedge clk_i);
         #2;
      end
      fe_queue_v_i = 1'b0;
      sent_cnt++;
   endtask

   task automatic run_phase(input int n, input int mode, input int max_gap);
      logic [INSTR_W-1:0] instr;
      logic [2:0]         prev;
      prev = 3'd1;
      for (int i = 0; i < n; i++) begin
         instr = gen_instr(mode, prev);
         prev  = instr[15:13];
         expect_instr(instr);
         send_instr(instr, int'(lcg_next() % (max_gap + 1)));
      end
   endtask

   task automatic cfg_write(input be_cfg_addr_e addr, input logic [DATA_W-1:0] data);
      cfg_we_i    = 1'b1;
      cfg_addr_i  = addr;
      cfg_wdata_i = data;
      @(posedge clk_i);
      #2;
      cfg_we_i = 1'b0;
   endtask

   task automatic cfg_read(input be_cfg_addr_e addr, input logic [REG_IDX_W-1:0] idx,
                           input logic [DATA_W-1:0] exp);
      cfg_addr_i = addr;
      cfg_idx_i  = idx;
      @(negedge clk_i);
      check_cfg(addr, idx, exp);
      @(posedge clk_i);
      #2;
   endtask

   task automatic wait_drain();
      while (exp_op.size() != 0 || exp_we.size() != 0) begin
         @(posedge clk_i);
         #2;
      end
      repeat (2) begin
         @(posedge clk_i);
         #2;
      end
   endtask

   initial begin
      logic [INSTR_W-1:0] held;
      rst_n_i         = 1'b0;
      fe_queue_i      = '0;
      fe_queue_v_i    = 1'b0;
      mem_credit_i    = 1'b0;
      mem_resp_v_i    = 1'b0;
      mem_resp_data_i = '0;
      cfg_we_i        = 1'b0;
      cfg_addr_i      = CFG_FREEZE;
      cfg_idx_i       = '0;
      cfg_wdata_i     = '0;
      for (int i = 0; i < 64; i++) begin
         ref_mem[i]   = fill_word(i);
         model_mem[i] = fill_word(i);
      end
      for (int i = 0; i < NUM_REGS; i++)
         ref_rf[i] = '0;
      repeat (3) @(posedge clk_i);
      #2;
      rst_n_i = 1'b1;

      run_phase(N_RAND, 0, 3);
      run_phase(N_CHAIN, 1, 0);
      run_phase(N_MEM, 2, 2);
      // Slow credit returns so the pool runs dry
      credit_lag = 12;
      run_phase(N_BURST, 3, 0);
      credit_lag = 0;
      wait_drain();

      // Freeze with two instructions still in flight
      run_phase(2, 0, 0);
      cfg_write(CFG_FREEZE, 32'd1);
      cfg_read(CFG_FREEZE, '0, 32'd1);
      held = gen_instr(0, 3'd1);
      expect_instr(held);
      fe_queue_i   = held;
      fe_queue_v_i = 1'b1;
      repeat (12) begin
         @(negedge clk_i);
         if (fe_queue_yumi_o)
            abort_run("an instruction was accepted while the back end was frozen");
         @(posedge clk_i);
         #2;
      end
      if (commit_cnt != sent_cnt)
         abort_run($sformatf("[FAIL] commit count expected %h got %h", sent_cnt, commit_cnt));
      cfg_write(CFG_FREEZE, 32'd0);
      send_instr(held, 0);
      run_phase(3, 2, 1);
      wait_drain();

      cfg_read(CFG_INSTRET, '0, DATA_W'(sent_cnt));
      for (int r = 0; r < NUM_REGS; r++)
         cfg_read(CFG_IRF, 3'(r), ref_rf[r]);
      if (commit_cnt == NUM_INSTR && sent_cnt == NUM_INSTR) begin
         $display("test passed");
         $finish;
      end else begin
         abort_run($sformatf("[FAIL] commit count expected %h got %h", NUM_INSTR, commit_cnt));
      end
   end

   // 40 cycles per instruction plus 200
   initial begin
      #((NUM_INSTR * 40 + 200) * 40);
      abort_run("watchdog expired before all instructions retired");
   end

endmodule : be_tb

//--- build.f
logic/be_pkg.sv
logic/be_cfg_regs.sv
logic/be_checker.sv
logic/be_calculator.sv
logic/be_mem.sv
logic/be_top.sv
test/be_props.sv
test/be_tb.sv

//--- Bender.yml
package:
  name: be_backend

sources:
  - files:
      - logic/be_pkg.sv
      - logic/be_cfg_regs.sv
      - logic/be_checker.sv
      - logic/be_calculator.sv
      - logic/be_mem.sv
      - logic/be_top.sv
  - target: test
    files:
      - test/be_props.sv
      - test/be_tb.sv
